// ==== Makefile ====
VERILATOR ?= verilator
FLAGS ?= --binary --timing --assert
TOP ?= fetch_tb
FILELIST ?= all.f
OBJ_DIR ?= obj_dir
PASS_TEXT ?= sim passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The exit status is that of grep, so a missing pass line fails the target.
run: compile
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q -x "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// ==== all.f ====
design/cpu_bus_pkg.sv
design/cpu_cache_pkg.sv
design/block_ram.sv
design/instruction_cache.sv
design/bus_arbiter.sv
design/main_memory.sv
design/fetch_system_top.sv
tests/bus_arbiter_chk.sv
tests/fetch_monitor.sv
tests/fetch_tb.sv

// ==== design/block_ram.sv ====
`default_nettype none

module block_ram #(
	parameter int DEPTH = 64,
	parameter type payload_t = logic [31:0]
) (
	input wire logic i_clock,
	input wire logic i_write,
	input wire logic [$clog2(DEPTH) - 1:0] i_address,
	input wire payload_t i_wdata,
	output payload_t o_rdata
);

	payload_t memory [DEPTH];

	// Read before write, data shows up one cycle after the address.
	always_ff @(posedge i_clock) begin
		if (i_write) begin
			memory[i_address] <= i_wdata;
		end
		o_rdata <= memory[i_address];
	end

endmodule

`default_nettype wire

// ==== design/bus_arbiter.sv ====
`default_nettype none

module bus_arbiter
	import cpu_bus_pkg::*;
(
	input wire logic i_clock,
	input wire logic i_reset,

	input wire bus_req_t i_fetch_req,
	output bus_rsp_t o_fetch_rsp,

	input wire bus_req_t i_data_req,
	output bus_rsp_t o_data_rsp,

	output bus_req_t o_mem_req,
	input wire bus_rsp_t i_mem_rsp
);

	// Bit 0 is the fetch side, bit 1 the data port.
	logic [1:0] grant;
	logic last_data;
	bus_req_t mem_req_q;
	logic pick_data;

	// When both ask, the side that was not served last wins.
	assign pick_data = i_data_req.request && (!i_fetch_req.request || !last_data);

	always_ff @(posedge i_clock) begin
		if (grant == 2'b00) begin
			if (i_fetch_req.request || i_data_req.request) begin
				grant <= pick_data ? 2'b10 : 2'b01;
				last_data <= pick_data;
			end
			mem_req_q <= pick_data ? i_data_req : i_fetch_req;
		end
		else begin
			mem_req_q <= grant[1] ? i_data_req : i_fetch_req;
			// The owner sees ready now and drops its request next cycle.
			if (i_mem_rsp.ready) begin
				grant <= 2'b00;
				mem_req_q.request <= 1'b0;
			end
		end

		if (i_reset) begin
			grant <= 2'b00;
			last_data <= 1'b0;
			mem_req_q.request <= 1'b0;
		end
	end

	assign o_mem_req = mem_req_q;

	// Only the owner of the grant sees the ready.
	assign o_fetch_rsp = '{
		ready: grant[0] && i_mem_rsp.ready,
		rdata: i_mem_rsp.rdata
	};
	assign o_data_rsp = '{
		ready: grant[1] && i_mem_rsp.ready,
		rdata: i_mem_rsp.rdata
	};

endmodule

`default_nettype wire

// ==== design/cpu_bus_pkg.sv ====
`default_nettype none

package cpu_bus_pkg;

	// Data or address word on the memory bus.
	typedef logic [31:0] word_t;

	// Held by the requester until ready.
	typedef struct packed {
		logic request;
		logic write;
		word_t address;
		word_t wdata;
	} bus_req_t;

	// Ready is a single-cycle pulse, rdata is valid with it on reads.
	typedef struct packed {
		logic ready;
		word_t rdata;
	} bus_rsp_t;

endpackage

`default_nettype wire

// ==== design/cpu_cache_pkg.sv ====
`default_nettype none

package cpu_cache_pkg;

	import cpu_bus_pkg::*;

	// One cached instruction, tagged with its full word address.
	typedef struct packed {
		logic valid;
		logic [29:0] tag;
		word_t instr;
	} icache_line_t;

	typedef enum logic [1:0] {
		state_idle = 2'd0,
		state_compare = 2'd1,
		state_bus_fill = 2'd2,
		state_clear = 2'd3
	} icache_state_t;

endpackage

`default_nettype wire

// ==== design/fetch_system_top.sv ====
`default_nettype none

module fetch_system_top
	import cpu_bus_pkg::*;
#(
	parameter int CACHE_INDEX_BITS = 6,
	parameter int MEM_ADDR_BITS = 10,
	parameter int MEM_LATENCY = 3
) (
	input wire logic i_clock,
	input wire logic i_reset,

	input wire word_t i_fetch_pc,
	input wire logic i_stall,
	output logic o_fetch_ready,
	output word_t o_fetch_instr,

	input wire bus_req_t i_data_req,
	output bus_rsp_t o_data_rsp
);

	bus_req_t fetch_req;
	bus_rsp_t fetch_rsp;
	bus_req_t mem_req;
	bus_rsp_t mem_rsp;

	instruction_cache #(
		.CACHE_INDEX_BITS(CACHE_INDEX_BITS)
	) cache_i (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_fetch_pc(i_fetch_pc),
		.i_stall(i_stall),
		.o_fetch_ready(o_fetch_ready),
		.o_fetch_instr(o_fetch_instr),
		.o_bus_req(fetch_req),
		.i_bus_rsp(fetch_rsp)
	);

	// Data port goes straight onto the second arbiter input.
	bus_arbiter arbiter_i (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_fetch_req(fetch_req),
		.o_fetch_rsp(fetch_rsp),
		.i_data_req(i_data_req),
		.o_data_rsp(o_data_rsp),
		.o_mem_req(mem_req),
		.i_mem_rsp(mem_rsp)
	);

	main_memory #(
		.MEM_ADDR_BITS(MEM_ADDR_BITS),
		.MEM_LATENCY(MEM_LATENCY)
	) memory_i (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_req(mem_req),
		.o_rsp(mem_rsp)
	);

endmodule

`default_nettype wire

// ==== design/instruction_cache.sv ====
`default_nettype none

module instruction_cache
	import cpu_bus_pkg::*;
	import cpu_cache_pkg::*;
#(
	parameter int CACHE_INDEX_BITS = 6
) (
	input wire logic i_clock,
	input wire logic i_reset,

	input wire word_t i_fetch_pc,
	input wire logic i_stall,
	output logic o_fetch_ready,
	output word_t o_fetch_instr,

	output bus_req_t o_bus_req,
	input wire bus_rsp_t i_bus_rsp
);

	icache_state_t state;
	logic [CACHE_INDEX_BITS - 1:0] clear_index;
	word_t held_pc;
	word_t next_pc;
	logic bus_request;

	logic ram_write;
	logic [CACHE_INDEX_BITS - 1:0] ram_address;
	icache_line_t ram_wdata;
	icache_line_t line;

	logic line_hit;
	logic pc_match;
	logic hit_accept;
	logic fill_done;

	// Direct mapped, the index sits just above the byte offset.
	block_ram #(
		.DEPTH(1 << CACHE_INDEX_BITS),
		.payload_t(icache_line_t)
	) line_ram (
		.i_clock(i_clock),
		.i_write(ram_write),
		.i_address(ram_address),
		.i_wdata(ram_wdata),
		.o_rdata(line)
	);

	assign next_pc = held_pc + 32'd4;
	assign line_hit = line.valid && (line.tag == held_pc[31:2]);
	assign pc_match = (i_fetch_pc == held_pc);
	assign hit_accept = (state == state_compare) && !i_stall && pc_match && line_hit;
	assign fill_done = (state == state_bus_fill) && i_bus_rsp.ready;

	// Clear writes invalid lines, a fill writes the returned word.
	assign ram_write = (state == state_clear) || fill_done;
	assign ram_wdata = '{
		valid: (state != state_clear),
		tag: held_pc[31:2],
		instr: i_bus_rsp.rdata
	};

	// A hit already points the RAM at pc + 4 so the next word streams.
	always_comb begin
		case (state)
			state_clear: ram_address = clear_index;
			state_idle: ram_address = i_fetch_pc[CACHE_INDEX_BITS + 1:2];
			state_compare: begin
				if (hit_accept) begin
					ram_address = next_pc[CACHE_INDEX_BITS + 1:2];
				end
				else begin
					ram_address = held_pc[CACHE_INDEX_BITS + 1:2];
				end
			end
			default: ram_address = held_pc[CACHE_INDEX_BITS + 1:2];
		endcase
	end

	assign o_bus_req = '{
		request: bus_request,
		write: 1'b0,
		address: {held_pc[31:2], 2'b00},
		wdata: '0
	};

	always_ff @(posedge i_clock) begin
		o_fetch_ready <= 1'b0;

		case (state)
			state_clear: begin
				clear_index <= clear_index + 1'b1;
				if (&clear_index) begin
					state <= state_idle;
				end
			end

			state_idle: begin
				// Skip the pc that was just delivered and is still presented.
				if (!i_stall && !(o_fetch_ready && pc_match)) begin
					held_pc <= i_fetch_pc;
					state <= state_compare;
				end
			end

			state_compare: begin
				if (i_stall) begin
					state <= state_idle;
				end
				else if (pc_match) begin
					if (line_hit) begin
						o_fetch_ready <= 1'b1;
						o_fetch_instr <= line.instr;
						held_pc <= next_pc;
					end
					else begin
						bus_request <= 1'b1;
						state <= state_bus_fill;
					end
				end
				else if (!o_fetch_ready) begin
					// Not sequential, look the new pc up from idle.
					state <= state_idle;
				end
			end

			state_bus_fill: begin
				if (i_bus_rsp.ready) begin
					bus_request <= 1'b0;
					o_fetch_ready <= 1'b1;
					o_fetch_instr <= i_bus_rsp.rdata;
					state <= state_idle;
				end
			end

			default: state <= state_clear;
		endcase

		// Every reset walks the whole array again.
		if (i_reset) begin
			state <= state_clear;
			clear_index <= '0;
			o_fetch_ready <= 1'b0;
			bus_request <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// ==== design/main_memory.sv ====
`default_nettype none

module main_memory
	import cpu_bus_pkg::*;
#(
	parameter int MEM_ADDR_BITS = 10,
	parameter int MEM_LATENCY = 3
) (
	input wire logic i_clock,
	input wire logic i_reset,

	input wire bus_req_t i_req,
	output bus_rsp_t o_rsp
);

	localparam int COUNT_BITS = (MEM_LATENCY > 1) ? $clog2(MEM_LATENCY) : 1;

	logic ready_q;
	logic [COUNT_BITS - 1:0] elapsed;
	logic mem_write;
	logic [MEM_ADDR_BITS - 1:0] mem_address;
	word_t mem_rdata;

	// Word addressed, bits above the array depth wrap.
	assign mem_address = i_req.address[MEM_ADDR_BITS + 1:2];

	// The write lands on the edge that ends the ready cycle.
	assign mem_write = ready_q && i_req.write;

	block_ram #(
		.DEPTH(1 << MEM_ADDR_BITS),
		.payload_t(word_t)
	) word_ram (
		.i_clock(i_clock),
		.i_write(mem_write),
		.i_address(mem_address),
		.i_wdata(i_req.wdata),
		.o_rdata(mem_rdata)
	);

	always_ff @(posedge i_clock) begin
		ready_q <= 1'b0;
		// The request is still up during ready and must not restart the count.
		if (!ready_q && i_req.request) begin
			if (elapsed == COUNT_BITS'(MEM_LATENCY - 1)) begin
				ready_q <= 1'b1;
				elapsed <= '0;
			end
			else begin
				elapsed <= elapsed + 1'b1;
			end
		end

		if (i_reset) begin
			ready_q <= 1'b0;
			elapsed <= '0;
		end
	end

	assign o_rsp = '{ready: ready_q, rdata: mem_rdata};

endmodule

`default_nettype wire

// ==== tests/bus_arbiter_chk.sv ====
`default_nettype none

module bus_arbiter_chk
	import cpu_bus_pkg::*;
(
	input wire logic i_clock,
	input wire logic i_reset,
	input wire logic [1:0] grant,
	input wire bus_req_t i_fetch_req,
	input wire bus_req_t i_data_req,
	input wire bus_req_t o_mem_req,
	input wire bus_rsp_t i_mem_rsp,
	input wire bus_rsp_t o_fetch_rsp,
	input wire bus_rsp_t o_data_rsp
);

	timeunit 1ns;
	timeprecision 100ps;

	int failures = 0;

	// A grant is held exactly as long as the memory sees a request.
	grant_onehot: assert property (@(posedge i_clock) disable iff (i_reset)
		$onehot0(grant) && ((grant != 2'b00) == o_mem_req.request))
	else begin
		$error("arbiter grant is not one-hot or does not match the memory request: %b", grant);
		failures++;
	end

	// The memory sees the same request until it answers.
	mem_req_stable: assert property (@(posedge i_clock) disable iff (i_reset)
		o_mem_req.request && !i_mem_rsp.ready |=>
		o_mem_req.request && $stable(o_mem_req.address) && $stable(o_mem_req.wdata))
	else begin
		$error("memory request changed before ready");
		failures++;
	end

	// The side that sees ready is the one whose request the memory served.
	rsp_to_owner: assert property (@(posedge i_clock) disable iff (i_reset)
		i_mem_rsp.ready |->
		$onehot({o_fetch_rsp.ready, o_data_rsp.ready}) &&
		(!o_fetch_rsp.ready || $past(i_fetch_req) == o_mem_req) &&
		(!o_data_rsp.ready || $past(i_data_req) == o_mem_req))
	else begin
		$error("response routed to a side without the grant");
		failures++;
	end

endmodule

bind bus_arbiter bus_arbiter_chk chk_i (.*);

`default_nettype wire

// ==== tests/fetch_monitor.sv ====
`default_nettype none

module fetch_monitor
	import cpu_bus_pkg::*;
#(
	parameter int MEM_ADDR_BITS = 10
) (
	input wire logic i_clock,
	input wire word_t i_fetch_pc,
	input wire logic i_fetch_ready,
	input wire word_t i_fetch_instr,
	input wire bus_req_t i_data_req,
	input wire bus_rsp_t i_data_rsp,
	output int o_error_count,
	output int o_fetch_count,
	output int o_data_count
);

	timeunit 1ns;
	timeprecision 100ps;

	localparam int DEPTH = 1 << MEM_ADDR_BITS;

	// Contents of main memory as written through the data port.
	word_t model [DEPTH];
	logic known [DEPTH];
	word_t last_pc;
	bus_req_t last_req;
	int fetch_errors = 0;
	int data_errors = 0;

	// Memory wraps on the word index, like the DUT.
	function automatic word_t expected_word(input word_t address);
		return model[address[MEM_ADDR_BITS + 1:2]];
	endfunction

	function automatic logic is_written(input word_t address);
		return known[address[MEM_ADDR_BITS + 1:2]];
	endfunction

	initial begin
		o_fetch_count = 0;
		o_data_count = 0;
		for (int i = 0; i < DEPTH; i++) begin
			known[i] = 1'b0;
		end
	end

	assign o_error_count = fetch_errors + data_errors;

	// The pc of the previous edge is the one that was held until ready.
	always @(posedge i_clock) begin
		if (i_fetch_ready) begin
			o_fetch_count++;
			if (!is_written(last_pc)) begin
				$display("fetch returned from address %h that was never written", last_pc);
				fetch_errors++;
			end
			else if (i_fetch_instr !== expected_word(last_pc)) begin
				$display("FAILED o_fetch_instr pc=%h expected=%h got=%h",
					last_pc, expected_word(last_pc), i_fetch_instr);
				fetch_errors++;
			end
		end
		last_pc = i_fetch_pc;
	end

	always @(posedge i_clock) begin
		if (i_data_rsp.ready) begin
			o_data_count++;
			if (last_req.write) begin
				model[last_req.address[MEM_ADDR_BITS + 1:2]] = last_req.wdata;
				known[last_req.address[MEM_ADDR_BITS + 1:2]] = 1'b1;
			end
			else if (!is_written(last_req.address)) begin
				$display("data read from address %h that was never written",
					last_req.address);
				data_errors++;
			end
			else if (i_data_rsp.rdata !== expected_word(last_req.address)) begin
				$display("FAILED o_data_rsp.rdata addr=%h expected=%h got=%h",
					last_req.address, expected_word(last_req.address), i_data_rsp.rdata);
				data_errors++;
			end
		end
		last_req = i_data_req;
	end

endmodule

`default_nettype wire

// ==== tests/fetch_tb.sv ====
`default_nettype none

module fetch_tb
	import cpu_bus_pkg::*;
;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int CACHE_INDEX_BITS = 6;
	localparam int MEM_ADDR_BITS = 10;
	localparam int MEM_LATENCY = 3;

	// Bus operations over all five tests.
	localparam int TOTAL_OPS = 64 + 32 + 16 + 80 + 32;
	// A miss under contention, widened for random stalls.
	localparam int WORST_CYCLES = 4 * 2 * (MEM_LATENCY + 4);
	localparam int CLEAR_CYCLES = 2 * (1 << CACHE_INDEX_BITS);
	localparam int WATCHDOG_NS = (TOTAL_OPS * WORST_CYCLES + CLEAR_CYCLES) * 10;

	logic i_clock;
	logic i_reset;
	word_t i_fetch_pc;
	logic i_stall;
	logic o_fetch_ready;
	word_t o_fetch_instr;
	bus_req_t i_data_req;
	bus_rsp_t o_data_rsp;

	int error_count;
	int fetch_count;
	int data_count;
	int cycle = 0;
	int tests_passed = 0;
	int tests_failed = 0;
	int errors_before;
	int first_pass;
	int second_pass;
	int fetch_issued = 0;
	int data_issued = 0;
	word_t seed = 32'he2f2_6720;

	fetch_system_top #(
		.CACHE_INDEX_BITS(CACHE_INDEX_BITS),
		.MEM_ADDR_BITS(MEM_ADDR_BITS),
		.MEM_LATENCY(MEM_LATENCY)
	) dut_i (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_fetch_pc(i_fetch_pc),
		.i_stall(i_stall),
		.o_fetch_ready(o_fetch_ready),
		.o_fetch_instr(o_fetch_instr),
		.i_data_req(i_data_req),
		.o_data_rsp(o_data_rsp)
	);

	fetch_monitor #(
		.MEM_ADDR_BITS(MEM_ADDR_BITS)
	) monitor_i (
		.i_clock(i_clock),
		.i_fetch_pc(i_fetch_pc),
		.i_fetch_ready(o_fetch_ready),
		.i_fetch_instr(o_fetch_instr),
		.i_data_req(i_data_req),
		.i_data_rsp(o_data_rsp),
		.o_error_count(error_count),
		.o_fetch_count(fetch_count),
		.o_data_count(data_count)
	);

	initial begin
		i_clock = 1'b0;
		forever #5 i_clock = ~i_clock;
	end

	always @(posedge i_clock) begin
		cycle++;
	end

	function automatic word_t lcg_next(input word_t state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	// Tasks start and end 1 ns after a rising edge.
	task automatic data_access(input logic write, input word_t address, input word_t wdata);
		data_issued++;
		i_data_req = '{request: 1'b1, write: write, address: address, wdata: wdata};
		do begin
			@(posedge i_clock);
			#1;
		end while (!o_data_rsp.ready);
		i_data_req.request = 1'b0;
	endtask

	task automatic fetch_word(input word_t pc, input logic stalls, inout word_t state);
		fetch_issued++;
		i_fetch_pc = pc;
		do begin
			if (stalls) begin
				state = lcg_next(state);
				i_stall = state[31] & state[30];
			end
			else begin
				i_stall = 1'b0;
			end
			@(posedge i_clock);
			#1;
		end while (!o_fetch_ready);
		// The cache fetches whatever pc it sees, so hold it off between fetches.
		i_stall = 1'b1;
	endtask

	task automatic write_program(input word_t base, input int words);
		for (int i = 0; i < words; i++) begin
			seed = lcg_next(seed);
			data_access(1'b1, base + 32'(4 * i), seed);
		end
	endtask

	task automatic run_loop(input word_t base, input int words, output int cycles);
		int start;
		word_t unused;
		start = cycle;
		unused = '0;
		for (int i = 0; i < words; i++) begin
			fetch_word(base + 32'(4 * i), 1'b0, unused);
		end
		cycles = cycle - start;
	endtask

	task automatic apply_reset();
		i_reset = 1'b1;
		repeat (3) @(posedge i_clock);
		#1;
		i_reset = 1'b0;
	endtask

	task automatic report_test(input string name, input logic extra_ok);
		// The monitor scores the last response on the next edge.
		@(posedge i_clock);
		#1;
		if (error_count == errors_before && extra_ok) begin
			$display("test %s: ok", name);
			tests_passed++;
		end
		else begin
			$display("test %s: %0d errors", name, error_count - errors_before);
			tests_failed++;
		end
		errors_before = error_count;
	endtask

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog: run did not finish within %0d ns", WATCHDOG_NS);
		$display("sim failed");
		$finish;
	end

	initial begin
		word_t read_seed;
		word_t stall_seed;
		i_reset = 1'b1;
		i_stall = 1'b1;
		i_fetch_pc = '0;
		i_data_req = '0;
		errors_before = 0;
		apply_reset();

		write_program(32'h0000_0000, 32);
		for (int i = 0; i < 32; i++) begin
			data_access(1'b0, 32'(4 * i), '0);
		end
		report_test("data_write_read", 1'b1);

		write_program(32'h0000_0100, 16);
		run_loop(32'h0000_0100, 16, first_pass);
		report_test("sequential_fetch", 1'b1);

		run_loop(32'h0000_0100, 16, second_pass);
		if (second_pass >= first_pass) begin
			$display("cached pass took %0d cycles, not fewer than the first %0d",
				second_pass, first_pass);
		end
		report_test("cached_loop", second_pass < first_pass);

		write_program(32'h0000_0200, 16);
		stall_seed = seed ^ 32'h5a5a_0f0f;
		read_seed = seed;
		fork
			for (int i = 0; i < 32; i++) begin
				fetch_word(32'h0000_0200 + 32'(4 * (i % 16)), 1'b1, stall_seed);
			end
			for (int i = 0; i < 32; i++) begin
				read_seed = lcg_next(read_seed);
				data_access(1'b0, {25'd0, read_seed[20:16], 2'b00}, '0);
			end
		join
		report_test("mixed_traffic", 1'b1);

		// These lines are still cached from the mixed traffic.
		apply_reset();
		write_program(32'h0000_0200, 16);
		run_loop(32'h0000_0200, 16, first_pass);
		report_test("reset_refetch", 1'b1);

		if (fetch_count != fetch_issued || data_count != data_issued) begin
			$display("ready count does not match the %0d fetches and %0d data accesses issued",
				fetch_issued, data_issued);
		end
		$display("tests passed %0d failed %0d, fetches %0d, data accesses %0d",
			tests_passed, tests_failed, fetch_count, data_count);
		if (tests_failed == 0 && error_count == 0 && fetch_count == fetch_issued
				&& data_count == data_issued && dut_i.arbiter_i.chk_i.failures == 0) begin
			$display("sim passed");
		end
		else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
